// File: source/periph_consts.svh
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// Data RAM depth in 32-bit words
`define RAM_WORDS 256

// Boot ROM depth in 32-bit words
`define ROM_WORDS 64

// Clock cycles per serial bit
`define UART_DIV 8

// ROM word i = ROM_KEY + i * 0x01010101
`define ROM_KEY 32'hA5C3_1E70

// Step between neighbouring ROM words
`define ROM_STEP 32'h0101_0101

`endif

// File: source/periph_pkg.sv
package periph_pkg;

	// Device select codes seen on the master request
	typedef enum logic [2:0] {
		SEL_RAM       = 3'd0,
		SEL_ROM       = 3'd1,
		SEL_UART      = 3'd2,
		SEL_UART_STAT = 3'd3,
		SEL_SEG       = 3'd4,
		SEL_NONE      = 3'd7
	} dev_sel_e;

	typedef enum logic [0:0] {
		ST_IDLE = 1'b0,
		ST_WAIT = 1'b1
	} bus_state_e;

	typedef struct packed {
		dev_sel_e    sel;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        we;
		logic        stb;   // Held until ack
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        ack;
	} bus_rsp_t;

	// Shared request to the device blocks, qualified by per-device strobes
	typedef struct packed {
		logic [7:0]  addr;
		logic [31:0] wdata;
		logic        we;
	} dev_req_t;

endpackage

// File: source/periph_bus.sv
`timescale 1ns/1ns

module periph_bus (
	input  logic                clk,
	input  logic                rst_n_i,
	input  periph_pkg::bus_req_t req_i,
	output periph_pkg::bus_rsp_t rsp_o,
	output periph_pkg::dev_req_t dev_o,
	output logic                ram_stb_o,
	output logic                rom_stb_o,
	output logic                uart_stb_o,
	output logic                seg_stb_o,
	input  logic [31:0]         ram_rdata_i,
	input  logic [31:0]         rom_rdata_i,
	input  logic [31:0]         seg_rdata_i,
	input  logic                ram_ack_i,
	input  logic                rom_ack_i,
	input  logic                uart_ack_i,
	input  logic                seg_ack_i,
	input  logic                uart_busy_i
);

	periph_pkg::bus_req_t   req_q;
	periph_pkg::bus_state_e state_q;
	logic                   done_q;     // Response already returned for this request
	logic                   loc_stb_q;  // Status and unmapped accesses
	logic                   loc_ack_q;
	logic                   ack_mux;
	logic [31:0]            rdata_mux;

	always_ff @(posedge clk) begin
		req_q <= req_i;
		if (!rst_n_i)
			req_q.stb <= 1'b0;
	end

	assign dev_o.addr  = req_q.addr[7:0];
	assign dev_o.wdata = req_q.wdata;
	assign dev_o.we    = req_q.we;

	// One strobe per request, issued only from idle
	always_ff @(posedge clk) begin
		ram_stb_o  <= 1'b0;
		rom_stb_o  <= 1'b0;
		uart_stb_o <= 1'b0;
		seg_stb_o  <= 1'b0;
		loc_stb_q  <= 1'b0;
		if (rst_n_i && state_q == periph_pkg::ST_IDLE && req_q.stb) begin
			case (req_q.sel)
				periph_pkg::SEL_RAM:  ram_stb_o <= 1'b1;
				periph_pkg::SEL_ROM:  rom_stb_o <= 1'b1;
				periph_pkg::SEL_SEG:  seg_stb_o <= 1'b1;
				periph_pkg::SEL_UART: begin
					uart_stb_o <= req_q.we;
					loc_stb_q  <= ~req_q.we;   // UART read acts as status read
				end
				default:              loc_stb_q <= 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			loc_ack_q <= 1'b0;
		else
			loc_ack_q <= loc_stb_q;
	end

	always_comb begin
		ack_mux   = loc_ack_q;
		rdata_mux = 32'd0;
		case (req_q.sel)
			periph_pkg::SEL_RAM: begin
				ack_mux   = ram_ack_i;
				rdata_mux = ram_rdata_i;
			end
			periph_pkg::SEL_ROM: begin
				ack_mux   = rom_ack_i;
				rdata_mux = rom_rdata_i;
			end
			periph_pkg::SEL_SEG: begin
				ack_mux   = seg_ack_i;
				rdata_mux = seg_rdata_i;
			end
			periph_pkg::SEL_UART: begin
				ack_mux   = req_q.we ? uart_ack_i : loc_ack_q;
				rdata_mux = req_q.we ? 32'd0 : {31'd0, uart_busy_i};
			end
			periph_pkg::SEL_UART_STAT: rdata_mux = {31'd0, uart_busy_i};
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		rsp_o.ack <= 1'b0;
		if (!rst_n_i) begin
			state_q <= periph_pkg::ST_IDLE;
			done_q  <= 1'b0;
		end else if (state_q == periph_pkg::ST_IDLE) begin
			done_q <= 1'b0;
			if (req_q.stb)
				state_q <= periph_pkg::ST_WAIT;
		end else begin
			if (!done_q && ack_mux) begin
				rsp_o.ack   <= 1'b1;
				rsp_o.rdata <= rdata_mux;
				done_q      <= 1'b1;
			end
			if (done_q && !req_q.stb)   // Master released the request
				state_q <= periph_pkg::ST_IDLE;
		end
	end

	a_one_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
		$onehot0({ram_stb_o, rom_stb_o, uart_stb_o, seg_stb_o, loc_stb_q}));

	a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
		rsp_o.ack |=> !rsp_o.ack);

endmodule

// File: source/data_ram.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module data_ram (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 stb_i,
	input  periph_pkg::dev_req_t dev_i,
	output logic [31:0]          rdata_o,
	output logic                 ack_o
);

	localparam int AW = $clog2(`RAM_WORDS);

	logic [31:0]   mem [`RAM_WORDS];
	logic [AW-1:0] addr;

	assign addr = dev_i.addr[AW-1:0];

	always_ff @(posedge clk) begin
		if (stb_i) begin
			if (dev_i.we)
				mem[addr] <= dev_i.wdata;
			else
				rdata_o <= mem[addr];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= stb_i;   // Single cycle latency
	end

	// Bridge must not restrobe while the previous access completes
	a_no_stb_on_ack: assert property (@(posedge clk) disable iff (!rst_n_i)
		ack_o |-> !stb_i);

endmodule

// File: source/boot_rom.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module boot_rom (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 stb_i,
	input  periph_pkg::dev_req_t dev_i,
	output logic [31:0]          rdata_o,
	output logic                 ack_o
);

	localparam int AW = $clog2(`ROM_WORDS);

	logic [31:0] rom_tab [`ROM_WORDS];

	// Fixed contents from the key rule
	always_comb begin
		for (int i = 0; i < `ROM_WORDS; i++)
			rom_tab[i] = `ROM_KEY + 32'(i) * `ROM_STEP;
	end

	// Writes still load rdata but the bridge drops it
	always_ff @(posedge clk) begin
		if (stb_i)
			rdata_o <= rom_tab[dev_i.addr[AW-1:0]];
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i)
			ack_o <= 1'b0;
		else
			ack_o <= stb_i;
	end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module uart_tx (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 stb_i,
	input  periph_pkg::dev_req_t dev_i,
	output logic                 ack_o,
	output logic                 busy_o,
	output logic                 tx_o
);

	localparam int DW = $clog2(`UART_DIV);

	logic          pend_q;     // Write waiting for the current frame to end
	logic          accept;
	logic          bit_end;
	logic [8:0]    frame_q;    // Data bits then stop bit
	logic [3:0]    bit_cnt_q;
	logic [DW-1:0] div_cnt_q;

	assign accept  = (pend_q || (stb_i && dev_i.we)) && !busy_o;
	assign bit_end = div_cnt_q == DW'(`UART_DIV - 1);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pend_q    <= 1'b0;
			ack_o     <= 1'b0;
			busy_o    <= 1'b0;
			tx_o      <= 1'b1;   // Line idles high
			bit_cnt_q <= '0;
			div_cnt_q <= '0;
		end else begin
			pend_q <= (pend_q || (stb_i && dev_i.we)) && busy_o;
			ack_o  <= accept;
			if (accept) begin
				frame_q   <= {1'b1, dev_i.wdata[7:0]};
				busy_o    <= 1'b1;
				tx_o      <= 1'b0;   // Start bit
				bit_cnt_q <= '0;
				div_cnt_q <= '0;
			end else if (busy_o) begin
				div_cnt_q <= bit_end ? '0 : div_cnt_q + 1'b1;
				if (bit_end) begin
					if (bit_cnt_q == 4'd9) begin
						busy_o <= 1'b0;
						tx_o   <= 1'b1;
					end else begin
						tx_o      <= frame_q[0];   // LSB first
						frame_q   <= {1'b1, frame_q[8:1]};
						bit_cnt_q <= bit_cnt_q + 1'b1;
					end
				end
			end
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (!rst_n_i)
		!busy_o |-> tx_o);

endmodule

// File: source/segdisp_regs.sv
`timescale 1ns/1ns

module segdisp_regs (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 stb_i,
	input  periph_pkg::dev_req_t dev_i,
	output logic [31:0]          rdata_o,
	output logic                 ack_o,
	output logic [6:0]           seg1_o,
	output logic [6:0]           seg0_o
);

	logic [7:0] byte_q;

	// Segments a..g on bits 6..0, active high
	function automatic logic [6:0] hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0: hex_seg = 7'h7E;
			4'h1: hex_seg = 7'h30;
			4'h2: hex_seg = 7'h6D;
			4'h3: hex_seg = 7'h79;
			4'h4: hex_seg = 7'h33;
			4'h5: hex_seg = 7'h5B;
			4'h6: hex_seg = 7'h5F;
			4'h7: hex_seg = 7'h70;
			4'h8: hex_seg = 7'h7F;
			4'h9: hex_seg = 7'h7B;
			4'hA: hex_seg = 7'h77;
			4'hB: hex_seg = 7'h1F;
			4'hC: hex_seg = 7'h4E;
			4'hD: hex_seg = 7'h3D;
			4'hE: hex_seg = 7'h4F;
			default: hex_seg = 7'h47;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			byte_q <= 8'h00;   // Shows 00 after reset
			ack_o  <= 1'b0;
		end else begin
			ack_o <= stb_i;
			if (stb_i && dev_i.we)
				byte_q <= dev_i.wdata[7:0];
		end
	end

	always_ff @(posedge clk) begin
		if (stb_i && !dev_i.we)
			rdata_o <= {24'd0, byte_q};
	end

	assign seg1_o = hex_seg(byte_q[7:4]);
	assign seg0_o = hex_seg(byte_q[3:0]);

endmodule

// File: source/periph_top.sv
`timescale 1ns/1ns

module periph_top (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  periph_pkg::bus_req_t req_i,
	output periph_pkg::bus_rsp_t rsp_o,
	output logic                 uart_tx_o,
	output logic [6:0]           seg1_o,
	output logic [6:0]           seg0_o
);

	periph_pkg::dev_req_t dev;
	logic                 ram_stb, rom_stb, uart_stb, seg_stb;
	logic                 ram_ack, rom_ack, uart_ack, seg_ack;
	logic [31:0]          ram_rdata, rom_rdata, seg_rdata;
	logic                 uart_busy;

	periph_bus u_periph_bus (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (req_i),
		.rsp_o       (rsp_o),
		.dev_o       (dev),
		.ram_stb_o   (ram_stb),
		.rom_stb_o   (rom_stb),
		.uart_stb_o  (uart_stb),
		.seg_stb_o   (seg_stb),
		.ram_rdata_i (ram_rdata),
		.rom_rdata_i (rom_rdata),
		.seg_rdata_i (seg_rdata),
		.ram_ack_i   (ram_ack),
		.rom_ack_i   (rom_ack),
		.uart_ack_i  (uart_ack),
		.seg_ack_i   (seg_ack),
		.uart_busy_i (uart_busy)
	);

	data_ram u_data_ram (.clk(clk), .rst_n_i(rst_n_i), .stb_i(ram_stb), .dev_i(dev),
		.rdata_o(ram_rdata), .ack_o(ram_ack));

	boot_rom u_boot_rom (.clk(clk), .rst_n_i(rst_n_i), .stb_i(rom_stb), .dev_i(dev),
		.rdata_o(rom_rdata), .ack_o(rom_ack));

	uart_tx u_uart_tx (.clk(clk), .rst_n_i(rst_n_i), .stb_i(uart_stb), .dev_i(dev),
		.ack_o(uart_ack), .busy_o(uart_busy), .tx_o(uart_tx_o));

	segdisp_regs u_segdisp_regs (.clk(clk), .rst_n_i(rst_n_i), .stb_i(seg_stb), .dev_i(dev),
		.rdata_o(seg_rdata), .ack_o(seg_ack), .seg1_o(seg1_o), .seg0_o(seg0_o));

endmodule

// File: dv/tb_periph_top.sv
`timescale 1ns/1ns
`include "periph_consts.svh"

module tb_periph_top;

	localparam int WAIT_LIMIT = 200;   // Cycles
	localparam int BUS_LAT    = 3;

	logic                 clk;
	logic                 rst_n;
	periph_pkg::bus_req_t req;
	periph_pkg::bus_rsp_t rsp;
	logic                 uart_tx;
	logic [6:0]           seg1;
	logic [6:0]           seg0;

	int seed = 94263;
	int n_checks;
	int n_errors;
	int test_errors;

	// Reference model
	logic [31:0] ram_shadow [`RAM_WORDS];
	logic        ram_valid [`RAM_WORDS];
	logic [7:0]  ram_written [$];
	logic [7:0]  seg_byte;
	logic [7:0]  uart_bytes [10];
	logic [6:0]  hex_tab [16] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B, 7'h5F, 7'h70,
		7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};

	periph_top u_periph_top (
		.clk       (clk),
		.rst_n_i   (rst_n),
		.req_i     (req),
		.rsp_o     (rsp),
		.uart_tx_o (uart_tx),
		.seg1_o    (seg1),
		.seg0_o    (seg0)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rom_word(input logic [5:0] idx);
		rom_word = `ROM_KEY + {26'd0, idx} * 32'h0101_0101;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		assert (got === exp) else begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			n_errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("Test %s done: %0d errors", name, n_errors - test_errors);
		test_errors = n_errors;
	endtask

	// Starts and returns on a falling edge
	task automatic bus_access(input logic [2:0] sel, input logic [31:0] addr,
		input logic [31:0] wdata, input logic we, output logic [31:0] rdata, output int lat);
		int cycles;
		req.sel   = periph_pkg::dev_sel_e'(sel);
		req.addr  = addr;
		req.wdata = wdata;
		req.we    = we;
		req.stb   = 1'b1;
		cycles    = 0;
		while (!rsp.ack && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (!rsp.ack) begin
			$display("Timeout: no acknowledge for select %0d within %0d cycles", sel, WAIT_LIMIT);
			$display("Simulation FAILED");
			$finish;
		end else begin
			rdata   = rsp.rdata;
			lat     = cycles - 1;   // First rising edge that sees stb counts as 0
			req.stb = 1'b0;
			repeat (2) @(negedge clk);
		end
	endtask

	task automatic ram_write(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		int          lat;
		bus_access(periph_pkg::SEL_RAM, addr, wdata, 1'b1, rdata, lat);
		check_equal("rsp_o.ack latency", lat, BUS_LAT);
		if (!ram_valid[addr[7:0]])
			ram_written.push_back(addr[7:0]);
		ram_valid[addr[7:0]]  = 1'b1;
		ram_shadow[addr[7:0]] = wdata;
	endtask

	task automatic ram_read(input logic [31:0] addr);
		logic [31:0] rdata;
		int          lat;
		bus_access(periph_pkg::SEL_RAM, addr, 32'd0, 1'b0, rdata, lat);
		check_equal("rsp_o.ack latency", lat, BUS_LAT);
		if (ram_valid[addr[7:0]])
			check_equal("rsp_o.rdata", rdata, ram_shadow[addr[7:0]]);
	endtask

	task automatic ram_op();
		logic [31:0] addr;
		int          idx;
		addr = $random(seed);
		if ($random(seed) & 1) begin
			ram_write(addr, $random(seed));
		end else begin
			if (ram_written.size() > 0 && ($random(seed) & 3) != 0) begin
				idx        = {$random(seed)} % ram_written.size();
				addr[7:0]  = ram_written[idx];   // Mostly hit written words
			end
			ram_read(addr);
		end
	endtask

	task automatic rom_op(input logic we, input logic [31:0] addr);
		logic [31:0] rdata;
		int          lat;
		bus_access(periph_pkg::SEL_ROM, addr, $random(seed), we, rdata, lat);
		check_equal("rsp_o.ack latency", lat, BUS_LAT);
		if (!we)
			check_equal("rsp_o.rdata", rdata, rom_word(addr[5:0]));
	endtask

	task automatic seg_op(input logic we);
		logic [31:0] wdata;
		logic [31:0] rdata;
		int          lat;
		wdata = $random(seed);
		bus_access(periph_pkg::SEL_SEG, $random(seed), wdata, we, rdata, lat);
		check_equal("rsp_o.ack latency", lat, BUS_LAT);
		if (we)
			seg_byte = wdata[7:0];
		else
			check_equal("rsp_o.rdata", rdata, {24'd0, seg_byte});
		check_equal("seg1_o", seg1, hex_tab[seg_byte[7:4]]);
		check_equal("seg0_o", seg0, hex_tab[seg_byte[3:0]]);
	endtask

	// Unmapped selects, and status reads while the UART is idle
	task automatic zero_op(input logic [2:0] sel, input logic we);
		logic [31:0] rdata;
		int          lat;
		bus_access(sel, $random(seed), $random(seed), we, rdata, lat);
		check_equal("rsp_o.ack latency", lat, BUS_LAT);
		check_equal("rsp_o.rdata", rdata, 32'd0);
	endtask

	task automatic uart_receive(input int n);
		int         b;
		int         k;
		int         cycles;
		logic [7:0] rx;
		for (b = 0; b < n; b++) begin
			cycles = 0;
			while (uart_tx !== 1'b0 && cycles < WAIT_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (uart_tx !== 1'b0) begin
				$display("Timeout: no UART start bit for byte %0d within %0d cycles", b, WAIT_LIMIT);
				$display("Simulation FAILED");
				$finish;
			end else begin
				repeat (`UART_DIV / 2) @(negedge clk);   // Middle of start bit
				check_equal("uart_tx_o start bit", uart_tx, 1'b0);
				for (k = 0; k < 8; k++) begin
					repeat (`UART_DIV) @(negedge clk);
					rx[k] = uart_tx;
				end
				repeat (`UART_DIV) @(negedge clk);
				check_equal("uart_tx_o stop bit", uart_tx, 1'b1);
				check_equal("uart_tx_o byte", rx, uart_bytes[b]);
			end
		end
	endtask

	initial begin
		int          i;
		int          k;
		int          lat;
		int          pick;
		logic [31:0] addr;
		logic [31:0] rnd;
		logic [31:0] rdata;
		req         = '0;
		rst_n       = 1'b0;
		n_checks    = 0;
		n_errors    = 0;
		test_errors = 0;
		seg_byte    = 8'h00;
		for (i = 0; i < `RAM_WORDS; i++)
			ram_valid[i] = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		check_equal("rsp_o.ack", rsp.ack, 1'b0);
		check_equal("uart_tx_o", uart_tx, 1'b1);
		check_equal("seg1_o", seg1, 7'h7E);
		check_equal("seg0_o", seg0, 7'h7E);
		end_test("reset");

		for (i = 0; i < 100; i++)
			ram_op();
		end_test("ram");

		for (i = 0; i < 40; i++)
			rom_op(1'b0, $random(seed));
		for (i = 0; i < 5; i++) begin
			addr = $random(seed);
			rom_op(1'b1, addr);
			rom_op(1'b0, addr);   // Write must leave the word unchanged
		end
		end_test("rom");

		for (i = 0; i < 30; i++) begin
			seg_op(1'b1);
			seg_op(1'b0);
		end
		end_test("seg");

		for (i = 0; i < 10; i++)
			uart_bytes[i] = $random(seed);
		fork
			begin
				for (k = 0; k < 10; k++) begin
					rnd = $random(seed);
					bus_access(periph_pkg::SEL_UART, 32'd0, {rnd[31:8], uart_bytes[k]}, 1'b1,
						rdata, lat);
				end
				bus_access(periph_pkg::SEL_UART_STAT, 32'd0, 32'd0, 1'b0, rdata, lat);
				check_equal("rsp_o.rdata", rdata, 32'd1);   // Last frame on the line
			end
			uart_receive(10);
		join
		repeat (2 * `UART_DIV) @(negedge clk);
		zero_op(periph_pkg::SEL_UART_STAT, 1'b0);
		zero_op(periph_pkg::SEL_UART, 1'b0);
		end_test("uart");

		zero_op(periph_pkg::SEL_NONE, 1'b0);
		zero_op(periph_pkg::SEL_NONE, 1'b1);
		for (i = 0; i < 60; i++) begin
			pick = {$random(seed)} % 8;
			case (pick)
				0, 1: ram_op();
				2: rom_op($random(seed), $random(seed));
				3: seg_op($random(seed));
				4: zero_op(($random(seed) & 1) ? 3'd3 : 3'd2, 1'b0);
				default: zero_op(pick, $random(seed));   // Codes 5 to 7
			endcase
		end
		foreach (ram_written[j])
			ram_read({24'd0, ram_written[j]});
		seg_op(1'b0);
		end_test("mixed");

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: tb.f
+incdir+source
source/periph_pkg.sv
source/periph_bus.sv
source/data_ram.sv
source/boot_rom.sv
source/uart_tx.sv
source/segdisp_regs.sv
source/periph_top.sv
dv/tb_periph_top.sv

// File: Bender.yml
package:
  name: periph_bridge

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/periph_pkg.sv
      - source/periph_bus.sv
      - source/data_ram.sv
      - source/boot_rom.sv
      - source/uart_tx.sv
      - source/segdisp_regs.sv
      - source/periph_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/tb_periph_top.sv
